// ==== common/isa_pkg.sv ====
// ================================================
// ISA definitions for the 40-bit instruction word:
// opcode names, field widths and the decoded views
// ================================================

package isa_pkg;

	localparam int INSN_W = 40;

	// Field widths
	localparam int REG_FIELD_W = 5;
	localparam int IMM_W       = 23;
	localparam int BDISP_W     = 18;
	localparam int JDISP_W     = 28;

	// Prefix word carries its payload from this bit up to the top
	localparam int PFX_LSB = 8;

	typedef enum logic [6:0] {
		NOP  = 7'h00,
		R2   = 7'h02,
		ADDI = 7'h04,
		ANDI = 7'h08,
		ORI  = 7'h09,
		XORI = 7'h0A,
		JMP  = 7'h20,
		BEQ  = 7'h26,
		BNE  = 7'h27,
		EXI  = 7'h50,
		LDB  = 7'h60,
		LDBU = 7'h61,
		LDW  = 7'h62,
		LDWU = 7'h63,
		LDO  = 7'h66,
		STB  = 7'h70,
		STW  = 7'h71,
		STO  = 7'h73
	} opcode_t;

	// ================================================
	// Instruction word views
	// ================================================
	typedef struct packed {
		logic [6:0]             unused;
		logic [5:0]             func;
		logic [REG_FIELD_W-1:0] rc;
		logic [REG_FIELD_W-1:0] rb;
		logic [REG_FIELD_W-1:0] ra;
		logic [REG_FIELD_W-1:0] rt;
		opcode_t                opcode;
	} r_form_t;

	typedef struct packed {
		logic [IMM_W-1:0]       imm;
		logic [REG_FIELD_W-1:0] ra;
		logic [REG_FIELD_W-1:0] rt;
		opcode_t                opcode;
	} i_form_t;

	// Bits 11:7 carry nothing in a branch
	typedef struct packed {
		logic [BDISP_W-1:0]     disp;
		logic [REG_FIELD_W-1:0] rb;
		logic [REG_FIELD_W-1:0] ra;
		logic [REG_FIELD_W-1:0] unused;
		opcode_t                opcode;
	} b_form_t;

	typedef struct packed {
		logic [JDISP_W-1:0]     disp;
		logic [REG_FIELD_W-1:0] lk;
		opcode_t                opcode;
	} j_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
		b_form_t b_form;
		j_form_t j_form;
	} instr_t;

	// Opcode groups shared by the decoder blocks
	function automatic logic is_load(opcode_t op);
		return op inside {LDB, LDBU, LDW, LDWU, LDO};
	endfunction

	function automatic logic is_store(opcode_t op);
		return op inside {STB, STW, STO};
	endfunction

	function automatic logic is_imm_op(opcode_t op);
		return op inside {ADDI, ANDI, ORI, XORI};
	endfunction

endpackage

// ==== common/decode_pkg.sv ====
// ================================================
// Decode result types: register indices, values,
// access sizes and the registered decode output
// ================================================

package decode_pkg;

	typedef logic [5:0] reg_idx_t;

	// Architectural stack pointer and the base of its banked copies
	localparam reg_idx_t SP_REG       = 6'd31;
	localparam reg_idx_t SP_BANK_BASE = 6'd42;

	localparam int VALUE_W = 64;
	typedef logic [VALUE_W-1:0] value_t;

	// Operating level selects the stack pointer bank
	typedef logic [2:0] sp_sel_t;

	typedef enum logic [1:0] {
		byt  = 2'd0,
		wyde = 2'd1,
		octa = 2'd3
	} memsz_t;

	// Upper immediate bits held from a prefix
	localparam int PFX_W = 32;

	typedef struct packed {
		logic             valid;
		logic [PFX_W-1:0] bits;
	} prefix_t;

	typedef struct packed {
		logic   rfwr;
		logic   ld;
		logic   ldz;
		logic   st;
		memsz_t memsz;
		logic   multi_cycle;
		logic   flowchg;
		logic   cbranch;
		logic   is_prefix;
	} op_class_t;

	typedef struct packed {
		reg_idx_t  ra;
		reg_idx_t  rb;
		reg_idx_t  rc;
		reg_idx_t  rt;
		value_t    imm;
		value_t    tgt;
		op_class_t cls;
	} deco_t;

endpackage

// ==== decoder/reg_select.sv ====
// ================================================
// Register selection: picks the four register
// indices and renames the banked stack pointer
// ================================================
`timescale 1ns/1ps

module reg_select #(
	parameter int NUM_SP_BANKS = 4
) (
	input  isa_pkg::instr_t      ir,
	input  decode_pkg::sp_sel_t  sp_sel,
	output decode_pkg::reg_idx_t ra,
	output decode_pkg::reg_idx_t rb,
	output decode_pkg::reg_idx_t rc,
	output decode_pkg::reg_idx_t rt
);
	import isa_pkg::*;
	import decode_pkg::*;

	opcode_t  op;
	reg_idx_t ra_arch;
	reg_idx_t rb_arch;
	reg_idx_t rc_arch;
	reg_idx_t rt_arch;
	logic     sp_banked;

	assign op = ir.r_form.opcode;

	// Level 0 and levels past the last bank keep the plain register
	assign sp_banked = (sp_sel != '0) && (int'(sp_sel) <= NUM_SP_BANKS);

	function automatic reg_idx_t rename_sp(reg_idx_t idx, logic banked, sp_sel_t sel);
		if (banked && idx == SP_REG)
			return SP_BANK_BASE + reg_idx_t'(sel);
		return idx;
	endfunction

	always_comb
	begin
		ra_arch = {1'b0, ir.r_form.ra};
		rb_arch = '0;
		rc_arch = '0;
		rt_arch = '0;

		if (op inside {JMP, NOP, EXI})
			ra_arch = '0;

		if (op == R2)
		begin
			rb_arch = {1'b0, ir.r_form.rb};
			rc_arch = {1'b0, ir.r_form.rc};
		end
		else if (op inside {BEQ, BNE})
			rb_arch = {1'b0, ir.b_form.rb};
		// Store data source sits in the target position
		else if (is_store(op))
			rc_arch = {1'b0, ir.i_form.rt};

		// Link register of a jump shares the target position
		if (op == R2 || is_imm_op(op) || is_load(op) || op == JMP)
			rt_arch = {1'b0, ir.r_form.rt};

		ra = rename_sp(ra_arch, sp_banked, sp_sel);
		rb = rename_sp(rb_arch, sp_banked, sp_sel);
		rc = rename_sp(rc_arch, sp_banked, sp_sel);
		rt = rename_sp(rt_arch, sp_banked, sp_sel);
	end

endmodule

// ==== decoder/imm_gen.sv ====
// ================================================
// Immediate generator: pads the immediate field,
// merges a held prefix and forms branch targets
// ================================================
`timescale 1ns/1ps

module imm_gen (
	input  isa_pkg::instr_t     ir,
	input  decode_pkg::prefix_t prefix,
	output decode_pkg::value_t  imm,
	output decode_pkg::value_t  tgt
);
	import isa_pkg::*;
	import decode_pkg::*;

	localparam int IMM_PAD  = VALUE_W - IMM_W;
	localparam int PFX_PAD  = VALUE_W - PFX_W - IMM_W;
	localparam int JTGT_PAD = VALUE_W - JDISP_W - 1;
	localparam int BTGT_PAD = VALUE_W - BDISP_W - 1;

	opcode_t            op;
	logic [IMM_W-1:0]   imm_field;
	logic [BDISP_W-1:0] bdisp;
	logic [JDISP_W-1:0] jdisp;
	value_t             imm_base;
	logic               takes_imm;

	assign op        = ir.i_form.opcode;
	assign imm_field = ir.i_form.imm;
	assign bdisp     = ir.b_form.disp;
	assign jdisp     = ir.j_form.disp;

	// ================================================
	// Immediate value
	// ================================================
	always_comb
	begin
		takes_imm = 1'b1;
		case (op)
			ADDI, LDB, LDBU, LDW, LDWU, LDO, STB, STW, STO:
				imm_base = {{IMM_PAD{imm_field[IMM_W-1]}}, imm_field};
			// Ones to the left keep an AND mask intact
			ANDI:
				imm_base = {{IMM_PAD{1'b1}}, imm_field};
			ORI, XORI:
				imm_base = {{IMM_PAD{1'b0}}, imm_field};
			default:
			begin
				imm_base  = '0;
				takes_imm = 1'b0;
			end
		endcase
	end

	// Prefix bits go above the low field, sign extended to full width
	assign imm = (prefix.valid && takes_imm)
		? {{PFX_PAD{prefix.bits[PFX_W-1]}}, prefix.bits, imm_field}
		: imm_base;

	// ================================================
	// Branch target, displacement in halfwords
	// ================================================
	always_comb
	begin
		case (op)
			JMP:
				tgt = {{JTGT_PAD{jdisp[JDISP_W-1]}}, jdisp, 1'b0};
			BEQ, BNE:
				tgt = {{BTGT_PAD{bdisp[BDISP_W-1]}}, bdisp, 1'b0};
			default:
				tgt = '0;
		endcase
	end

endmodule

// ==== decoder/op_classify.sv ====
// ================================================
// Operation classifier: register-file write flag,
// memory access class and control-flow flags
// ================================================
`timescale 1ns/1ps

module op_classify (
	input  isa_pkg::instr_t       ir,
	output decode_pkg::op_class_t cls
);
	import isa_pkg::*;
	import decode_pkg::*;

	opcode_t op;
	logic    link_used;

	assign op = ir.j_form.opcode;

	// Link field of zero means a plain jump without a return address
	assign link_used = ir.j_form.lk != '0;

	always_comb
	begin
		cls = '0;

		// ================================================
		// Memory access
		// ================================================
		cls.ld  = is_load(op);
		cls.ldz = op inside {LDBU, LDWU};
		cls.st  = is_store(op);

		// Every memory access stalls the pipe for the bus cycle
		cls.multi_cycle = is_load(op) || is_store(op);

		case (op)
			LDB, LDBU, STB:
				cls.memsz = byt;
			LDW, LDWU, STW:
				cls.memsz = wyde;
			default:
				cls.memsz = octa;
		endcase

		// ================================================
		// Control flow
		// ================================================
		cls.flowchg   = op inside {JMP, BEQ, BNE};
		cls.cbranch   = op inside {BEQ, BNE};
		cls.is_prefix = op == EXI;

		// Register file write
		case (op)
			R2:
				cls.rfwr = 1'b1;
			JMP:
				cls.rfwr = link_used;
			default:
				cls.rfwr = is_imm_op(op) || is_load(op);
		endcase
	end

endmodule

// ==== src/decode_stage.sv ====
// ================================================
// Decode stage register: holds a pending prefix
// and registers the decode result with its strobe
// ================================================
`timescale 1ns/1ps

module decode_stage (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ir_valid,
	input  logic                         is_prefix,
	input  logic [decode_pkg::PFX_W-1:0] prefix_bits,
	input  decode_pkg::deco_t            deco_next,
	output decode_pkg::prefix_t          prefix,
	output decode_pkg::deco_t            deco,
	output logic                         deco_valid
);

	logic                         pfx_valid;
	logic [decode_pkg::PFX_W-1:0] pfx_bits;
	logic                         take_prefix;
	logic                         take_insn;

	assign take_prefix = ir_valid && is_prefix;
	assign take_insn   = ir_valid && !is_prefix;

	// ================================================
	// Control state
	// ================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pfx_valid  <= 1'b0;
			deco_valid <= 1'b0;
		end
		else
		begin
			deco_valid <= take_insn;
			// Any accepted instruction consumes the prefix, used or not
			if (ir_valid)
				pfx_valid <= is_prefix;
		end
	end

	// Payload
	always_ff @(posedge clk)
	begin
		// A newer prefix replaces an older one
		if (take_prefix)
			pfx_bits <= prefix_bits;
		if (take_insn)
			deco <= deco_next;
	end

	assign prefix = '{valid: pfx_valid, bits: pfx_bits};

	// A prefix never produces an output of its own
	prefix_no_output_a: assert property (
		@(posedge clk) disable iff (!rst_n)
		deco_valid |-> !deco.cls.is_prefix
	) else
		$error("prefix word registered as a decode result");

endmodule

// ==== src/insn_decoder.sv ====
// ================================================
// Instruction decoder top level: combinational
// decode blocks feeding the stage register
// ================================================
`timescale 1ns/1ps

module insn_decoder #(
	parameter int NUM_SP_BANKS = 4
) (
	input  logic                clk,
	input  logic                rst_n,
	input  isa_pkg::instr_t     ir,
	input  logic                ir_valid,
	input  decode_pkg::sp_sel_t sp_sel,
	output decode_pkg::deco_t   deco,
	output logic                deco_valid
);
	import isa_pkg::*;
	import decode_pkg::*;

	reg_idx_t         ra;
	reg_idx_t         rb;
	reg_idx_t         rc;
	reg_idx_t         rt;
	value_t           imm;
	value_t           tgt;
	op_class_t        cls;
	prefix_t          prefix;
	logic [PFX_W-1:0] prefix_bits;
	deco_t            deco_next;

	reg_select #(
		.NUM_SP_BANKS(NUM_SP_BANKS)
	) u_reg_select (
		.ir    (ir),
		.sp_sel(sp_sel),
		.ra    (ra),
		.rb    (rb),
		.rc    (rc),
		.rt    (rt)
	);

	imm_gen u_imm_gen (
		.ir    (ir),
		.prefix(prefix),
		.imm   (imm),
		.tgt   (tgt)
	);

	op_classify u_op_classify (
		.ir (ir),
		.cls(cls)
	);

	// Upper immediate payload of a prefix word
	assign prefix_bits = ir[INSN_W-1:PFX_LSB];

	assign deco_next = '{ra: ra, rb: rb, rc: rc, rt: rt, imm: imm, tgt: tgt, cls: cls};

	decode_stage u_decode_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.ir_valid   (ir_valid),
		.is_prefix  (cls.is_prefix),
		.prefix_bits(prefix_bits),
		.deco_next  (deco_next),
		.prefix     (prefix),
		.deco       (deco),
		.deco_valid (deco_valid)
	);

endmodule

// ==== verification/tb_insn_decoder.sv ====
// ================================================
// Instruction decoder testbench: table of stimulus
// and expected decode results applied in a loop
// ================================================
`timescale 1ns/1ps

module tb_insn_decoder;
	import isa_pkg::*;
	import decode_pkg::*;

	localparam int          NUM_SP_BANKS = 4;
	localparam logic [31:0] SEED         = 32'h0057_5f3b;

	logic      clk = 1'b0;
	logic      rst_n;
	instr_t    ir;
	logic      ir_valid;
	sp_sel_t   sp_sel;
	deco_t     deco;
	logic      deco_valid;

	// Stimulus and expected values, one column per queue
	logic [39:0] tbl_word[$];
	sp_sel_t     tbl_sel[$];
	logic        tbl_pfx[$];
	deco_t       tbl_exp[$];
	string       tbl_name[$];

	// Prefix state of the reference model while the table is built
	logic        model_pfx_valid = 1'b0;
	logic [31:0] model_pfx_bits  = '0;

	int errors        = 0;
	int tests_run     = 0;
	int tests_passed  = 0;
	int cycle_count   = 0;
	int timeout_limit = 1000;

	insn_decoder #(
		.NUM_SP_BANKS(NUM_SP_BANKS)
	) DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.ir        (ir),
		.ir_valid  (ir_valid),
		.sp_sel    (sp_sel),
		.deco      (deco),
		.deco_valid(deco_valid)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("Checks failed");
			$finish;
		end
	end

	// ================================================
	// Reference model
	// ================================================
	function automatic reg_idx_t bank_sp(input reg_idx_t idx, input sp_sel_t sel);
		if (idx == 6'd31 && sel >= 3'd1 && int'(sel) <= NUM_SP_BANKS)
			return 6'd42 + {3'b000, sel};
		return idx;
	endfunction

	function automatic deco_t ref_decode(input logic [39:0] w, input sp_sel_t sel,
			input logic pv, input logic [31:0] pb);
		deco_t       d;
		opcode_t     op;
		logic [22:0] imm23;
		logic [17:0] bd;
		logic [27:0] jd;
		logic        ld_op;
		logic        st_op;
		logic        imm_op;
		op     = opcode_t'(w[6:0]);
		imm23  = w[39:17];
		bd     = w[39:22];
		jd     = w[39:12];
		ld_op  = op == LDB || op == LDBU || op == LDW || op == LDWU || op == LDO;
		st_op  = op == STB || op == STW || op == STO;
		imm_op = op == ADDI || op == ANDI || op == ORI || op == XORI;
		d = '0;

		if (op != JMP && op != NOP && op != EXI)
			d.ra = {1'b0, w[16:12]};
		if (op == R2 || op == BEQ || op == BNE)
			d.rb = {1'b0, w[21:17]};
		if (op == R2)
			d.rc = {1'b0, w[26:22]};
		else if (st_op)
			d.rc = {1'b0, w[11:7]};
		if (op == R2 || imm_op || ld_op || op == JMP)
			d.rt = {1'b0, w[11:7]};
		d.ra = bank_sp(d.ra, sel);
		d.rb = bank_sp(d.rb, sel);
		d.rc = bank_sp(d.rc, sel);
		d.rt = bank_sp(d.rt, sel);

		if (imm_op || ld_op || st_op)
		begin
			if (pv)
				d.imm = {{9{pb[31]}}, pb, imm23};
			else if (op == ANDI)
				d.imm = {{41{1'b1}}, imm23};
			else if (op == ORI || op == XORI)
				d.imm = {41'd0, imm23};
			else
				d.imm = {{41{imm23[22]}}, imm23};
		end
		if (op == JMP)
			d.tgt = {{35{jd[27]}}, jd, 1'b0};
		else if (op == BEQ || op == BNE)
			d.tgt = {{45{bd[17]}}, bd, 1'b0};

		d.cls.ld  = ld_op;
		d.cls.ldz = op == LDBU || op == LDWU;
		d.cls.st  = st_op;
		if (op == LDB || op == LDBU || op == STB)
			d.cls.memsz = byt;
		else if (op == LDW || op == LDWU || op == STW)
			d.cls.memsz = wyde;
		else
			d.cls.memsz = octa;
		d.cls.multi_cycle = ld_op || st_op;
		d.cls.flowchg     = op == JMP || op == BEQ || op == BNE;
		d.cls.cbranch     = op == BEQ || op == BNE;
		d.cls.is_prefix   = op == EXI;
		d.cls.rfwr        = op == R2 || imm_op || ld_op || (op == JMP && w[11:7] != 5'd0);
		return d;
	endfunction

	// ================================================
	// Instruction word builders, spare bits random
	// ================================================
	function automatic logic [39:0] rand_word(input opcode_t op);
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return {r[39:7], op};
	endfunction

	function automatic logic [39:0] r_word(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] rc);
		logic [39:0] w;
		w = rand_word(op);
		w[26:7] = {rc, rb, ra, rt};
		return w;
	endfunction

	function automatic logic [39:0] i_word(input opcode_t op, input logic [4:0] rt,
			input logic [4:0] ra, input logic [22:0] imm);
		logic [39:0] w;
		w = rand_word(op);
		w[39:7] = {imm, ra, rt};
		return w;
	endfunction

	function automatic logic [39:0] b_word(input opcode_t op, input logic [4:0] ra,
			input logic [4:0] rb, input logic [17:0] disp);
		logic [39:0] w;
		w = rand_word(op);
		w[39:12] = {disp, rb, ra};
		return w;
	endfunction

	function automatic logic [39:0] j_word(input logic [4:0] lk, input logic [27:0] disp);
		logic [39:0] w;
		w = rand_word(JMP);
		w[39:7] = {disp, lk};
		return w;
	endfunction

	function automatic logic [39:0] x_word(input logic [31:0] bits);
		logic [39:0] w;
		w = rand_word(EXI);
		w[39:8] = bits;
		return w;
	endfunction

	function automatic opcode_t imm_op_at(input int k);
		case (k)
			0: return ADDI;
			1: return ANDI;
			2: return ORI;
			default: return XORI;
		endcase
	endfunction

	function automatic opcode_t mem_op_at(input int k);
		case (k)
			0: return LDB;
			1: return LDBU;
			2: return LDW;
			3: return LDWU;
			4: return LDO;
			5: return STB;
			6: return STW;
			default: return STO;
		endcase
	endfunction

	// ================================================
	// Table construction
	// ================================================
	task automatic add_entry(input string name, input logic [39:0] w, input sp_sel_t sel);
		logic pfx;
		pfx = w[6:0] == EXI;
		tbl_name.push_back(name);
		tbl_word.push_back(w);
		tbl_sel.push_back(sel);
		tbl_pfx.push_back(pfx);
		tbl_exp.push_back(ref_decode(w, sel, model_pfx_valid, model_pfx_bits));
		// Any accepted instruction consumes a pending prefix
		model_pfx_valid = pfx;
		if (pfx)
			model_pfx_bits = w[39:8];
	endtask

	task automatic build_table();
		opcode_t op;
		add_entry("r2_fields", r_word(R2, 5'd1, 5'd2, 5'd3, 5'd4), 3'd0);
		for (int s = 0; s < 7; s++)
			add_entry($sformatf("sp_sel_%0d", s), r_word(R2, 5'd31, 5'd31, 5'd31, 5'd31), 3'(s));
		for (int k = 0; k < 4; k++)
		begin
			op = imm_op_at(k);
			add_entry($sformatf("%s_neg", op.name()), i_word(op, 5'd5, 5'd6, 23'h400123), 3'd0);
			add_entry($sformatf("%s_pos", op.name()), i_word(op, 5'd5, 5'd6, 23'h012345), 3'd0);
		end
		add_entry("exi_first", x_word(32'h8000_1234), 3'd0);
		add_entry("addi_prefixed", i_word(ADDI, 5'd7, 5'd8, 23'h000abc), 3'd0);
		add_entry("addi_after", i_word(ADDI, 5'd7, 5'd8, 23'h7f0001), 3'd0);
		add_entry("exi_older", x_word(32'h0000_5555), 3'd0);
		add_entry("exi_newer", x_word(32'hffff_0002), 3'd0);
		add_entry("addi_newer", i_word(ADDI, 5'd9, 5'd10, 23'h000010), 3'd0);
		for (int k = 0; k < 8; k++)
		begin
			op = mem_op_at(k);
			add_entry(op.name(), i_word(op, 5'd12, 5'd31, 23'h7ffff0), 3'd0);
		end
		add_entry("jmp_nolink", j_word(5'd0, 28'h000_0100), 3'd0);
		add_entry("jmp_link", j_word(5'd1, 28'hfff_ff00), 3'd0);
		add_entry("beq_fwd", b_word(BEQ, 5'd3, 5'd4, 18'h00040), 3'd0);
		add_entry("beq_back", b_word(BEQ, 5'd3, 5'd4, 18'h3ffc0), 3'd0);
		add_entry("bne_fwd", b_word(BNE, 5'd13, 5'd14, 18'h1ffff), 3'd0);
		add_entry("bne_back", b_word(BNE, 5'd13, 5'd14, 18'h20000), 3'd0);
	endtask

	// ================================================
	// Checks and reporting
	// ================================================
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got === expected)
		else
		begin
			$display("[ERROR] %0t %s: got 0x%0h expected 0x%0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs == 0)
			tests_passed++;
		$display("Test %0d %s: %s", tests_run, name, (errs == 0) ? "ok" : "FAILED");
	endtask

	task automatic check_entry(input int k);
		deco_t expected;
		int    errs_before;
		expected    = tbl_exp[k];
		errs_before = errors;
		// A prefix is held silently
		if (tbl_pfx[k])
			check_value("deco_valid", 64'(deco_valid), 64'd0);
		else
		begin
			check_value("deco_valid", 64'(deco_valid), 64'd1);
			check_value("deco.ra", 64'(deco.ra), 64'(expected.ra));
			check_value("deco.rb", 64'(deco.rb), 64'(expected.rb));
			check_value("deco.rc", 64'(deco.rc), 64'(expected.rc));
			check_value("deco.rt", 64'(deco.rt), 64'(expected.rt));
			check_value("deco.imm", deco.imm, expected.imm);
			check_value("deco.tgt", deco.tgt, expected.tgt);
			check_value("deco.cls", 64'(deco.cls), 64'(expected.cls));
		end
		report_test(tbl_name[k], errors - errs_before);
	endtask

	initial
	begin
		int errs_before;
		void'($urandom(SEED));
		rst_n    = 1'b0;
		ir       = '0;
		ir_valid = 1'b0;
		sp_sel   = '0;
		build_table();
		timeout_limit = 2 * tbl_word.size() + 20;

		repeat (10) @(posedge clk);
		#10;
		rst_n       = 1'b1;
		errs_before = errors;
		check_value("deco_valid", 64'(deco_valid), 64'd0);
		report_test("reset", errors - errs_before);

		// Each result is checked one cycle after its instruction is driven
		for (int i = 0; i <= tbl_word.size(); i++)
		begin
			@(posedge clk);
			#10;
			if (i > 0)
				check_entry(i - 1);
			if (i < tbl_word.size())
			begin
				ir       = tbl_word[i];
				sp_sel   = tbl_sel[i];
				ir_valid = 1'b1;
			end
			else
				ir_valid = 1'b0;
		end

		$display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_run, tests_passed, tests_run - tests_passed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== insn_decoder.f ====
common/isa_pkg.sv
common/decode_pkg.sv
decoder/reg_select.sv
decoder/imm_gen.sv
decoder/op_classify.sv
src/decode_stage.sv
src/insn_decoder.sv
verification/tb_insn_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the instruction decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module tb_insn_decoder \
	-f insn_decoder.f \
	--Mdir "$BUILD" -o tb_insn_decoder \
	&& "./$BUILD/tb_insn_decoder" > "$LOG" 2>&1 \
	|| echo "Build or simulation did not complete"

cat "$LOG" 2>/dev/null

grep -qx "All checks passed" "$LOG" 2>/dev/null \
	&& { echo "Result: PASS"; exit 0; } \
	|| { echo "Result: FAIL"; exit 1; }
